// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/issue_pkg.sv
      - hdl/issue_window.sv
      - hdl/operand_hazard.sv
      - hdl/pipe_classify.sv
      - hdl/dual_select.sv
      - hdl/issue_stage.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/issue_stage_properties.sv
      - bench/issue_stage_tb.sv

// ==== bench/issue_stage_properties.sv ====
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_stage_properties (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      stall,
  input  logic [`ISSUE_KEY_BITS:0]  free,
  input  issue_pkg::issue_slot_t    slot0,
  input  issue_pkg::issue_slot_t    slot1
);

  int failures = 0;  // failed assertion count.

  stall_tracks_free: assert property (@(posedge clk) disable iff (reset)
    stall == (free < 2)) else begin
    failures++;
    $error("stall does not follow the free count");
  end

  free_in_range: assert property (@(posedge clk) disable iff (reset)
    free <= `ISSUE_DEPTH) else begin
    failures++;
    $error("free count above window depth");
  end

  // slots blank for the whole flush cycle.
  flush_blanks_slots: assert property (@(posedge clk) disable iff (reset)
    flush |-> !slot0.valid && !slot1.valid) else begin
    failures++;
    $error("slot valid during flush");
  end

  distinct_ids: assert property (@(posedge clk) disable iff (reset)
    (slot0.valid && slot1.valid) |-> slot0.entry.id != slot1.entry.id) else begin
    failures++;
    $error("both slots carry the same id");
  end

endmodule

bind issue_stage issue_stage_properties checks (
  .clk(clk), .reset(reset), .flush(flush), .stall(stall), .free(free),
  .slot0(slot0), .slot1(slot1)
);

// ==== bench/issue_stage_tb.sv ====
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_stage_tb;
  import issue_pkg::*;

  typedef struct packed {
    issue_slot_t              s0;
    issue_slot_t              s1;
    logic [`ISSUE_KEY_BITS:0] free;
  } expect_t;

  logic                      clk;
  logic                      reset;
  logic                      flush;
  logic                      push0;
  logic                      push1;
  instr_entry_t              entry_in0;
  instr_entry_t              entry_in1;
  logic [`INST_WIDTH-1:0]    dec_instruction;
  logic                      dec_is_load;
  logic                      stall;
  logic [`ISSUE_KEY_BITS:0]  free;
  issue_slot_t               slot0;
  issue_slot_t               slot1;

  instr_entry_t          model_q [$];  // oldest first.
  logic [`ID_WIDTH-1:0]  next_id = '0;
  int                    checks = 0;
  int                    errors = 0;
  int                    timeouts = 0;

  issue_stage UUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic reads_reg(input logic [`INST_WIDTH-1:0] inst,
                                     input logic [`REG_BITS-1:0] r);
    logic [5:0] op;
    logic       rs_used;
    logic       rt_used;
    op = inst[`OPCODE_MSB:`OPCODE_LSB];
    rs_used = (op != `OP_NOP && op[5] == 1'b0) || op == `OP_LW || op == `OP_SW;
    rt_used = (op[5:4] == `OP_GRP_ALU_REG && op != `OP_NOP && op != `OP_JR) || op == `OP_SW;
    return (rs_used && inst[`RS_MSB:`RS_LSB] == r) || (rt_used && inst[`RT_MSB:`RT_LSB] == r);
  endfunction

  // {writes, register}.
  function automatic logic [5:0] dest_of(input logic [`INST_WIDTH-1:0] inst);
    logic [5:0] op;
    op = inst[`OPCODE_MSB:`OPCODE_LSB];
    if (op == `OP_NOP || op == `OP_JR)
      return '0;
    if (op[5:4] == `OP_GRP_ALU_REG)
      return {1'b1, inst[`RD_MSB:`RD_LSB]};
    if (op[5:4] == `OP_GRP_ALU_IMM || op == `OP_LW)
      return {1'b1, inst[`RT_MSB:`RT_LSB]};
    return '0;
  endfunction

  function automatic pipe_class_t class_of(input logic [`INST_WIDTH-1:0] inst);
    logic [5:0] op;
    op = inst[`OPCODE_MSB:`OPCODE_LSB];
    if (op[5:4] == `OP_GRP_MEM)
      return pipe_memory;
    if (op[5:4] == `OP_GRP_BRANCH || op == `OP_JR || op == `OP_CMP || op == `OP_TEST ||
        op == `OP_CMPI || op == `OP_TESTI)
      return pipe_branch;
    return pipe_any;
  endfunction

  function automatic expect_t predict(input logic [`INST_WIDTH-1:0] dec, input logic ld,
                                      input logic fl);
    expect_t                 e;
    logic [`ISSUE_DEPTH-1:0] rdy;
    logic [5:0]              d;
    int                      k0;
    int                      k1;
    pipe_class_t             c0;
    e = '0;
    rdy = '0;
    k0 = -1;
    k1 = -1;
    c0 = pipe_any;
    e.free = `ISSUE_DEPTH - model_q.size();
    for (int i = 0; i < model_q.size(); i++) begin
      rdy[i] = !(ld && reads_reg(model_q[i].instruction, dec[`RT_MSB:`RT_LSB]));
      for (int j = 0; j < i; j++) begin
        d = dest_of(model_q[j].instruction);
        if (d[5] && reads_reg(model_q[i].instruction, d[4:0]))
          rdy[i] = 1'b0;  // raw on older producer.
      end
      if (rdy[i] && k0 < 0) begin
        k0 = i;
        c0 = class_of(model_q[i].instruction);
      end
    end
    for (int i = 0; i < model_q.size(); i++) begin
      if (rdy[i] && i != k0 && k1 < 0 &&
          (c0 == pipe_any || class_of(model_q[i].instruction) != c0))
        k1 = i;
    end
    if (fl || k0 < 0)
      return e;
    if (c0 == pipe_memory || (k1 >= 0 && class_of(model_q[k1].instruction) == pipe_branch)) begin
      e.s1 = {1'b1, model_q[k0]};
      if (k1 >= 0)
        e.s0 = {1'b1, model_q[k1]};
    end else begin
      e.s0 = {1'b1, model_q[k0]};
      if (k1 >= 0)
        e.s1 = {1'b1, model_q[k1]};
    end
    return e;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic instr_entry_t make_instr(input logic [5:0] op, input int rs,
                                              input int rt, input int rd);
    instr_entry_t e;
    e.instruction = {op, 5'(rs), 5'(rt), 5'(rd), 11'($urandom)};
    e.pc = $urandom;
    e.branch_target = $urandom;
    e.branch_taken = $urandom % 2;
    e.id = next_id;
    next_id = next_id + 1'b1;
    return e;
  endfunction

  function automatic instr_entry_t rand_instr();
    logic [5:0] ops [9];
    ops = '{`OP_NOP, `OP_JR, `OP_CMP, 6'h08, 6'h18, `OP_TESTI, `OP_LW, `OP_SW, 6'h31};
    return make_instr(ops[$urandom % 9], $urandom % 8, $urandom % 8, $urandom % 8);
  endfunction

  task automatic compare_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("** Error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // one clock of pushes, driven 1 ns after the edge.
  task automatic step(input logic p0, input instr_entry_t e0, input logic p1,
                      input instr_entry_t e1);
    push0 = p0;
    entry_in0 = e0;
    push1 = p1;
    entry_in1 = e1;
    @(posedge clk);
    #1;
    push0 = 1'b0;
    push1 = 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (free !== `ISSUE_DEPTH && t < 40) begin
      step(1'b0, '0, 1'b0, '0);
      t++;
    end
    if (free !== `ISSUE_DEPTH) begin
      timeouts++;
      $display("window did not drain within 40 cycles");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare and model update
  //////////////////////////////////////////////////////////////////////

  initial begin : compare_outputs
    expect_t e;
    forever begin
      @(posedge clk);
      #8;
      e = predict(dec_instruction, dec_is_load, flush);
      if (!reset) begin
        compare_value("slot0", e.s0, slot0);
        compare_value("slot1", e.s1, slot1);
        compare_value("free", e.free, free);
        compare_value("stall", e.free < 2, stall);
      end
      if (reset || flush) begin
        model_q.delete();
      end else begin
        for (int i = model_q.size() - 1; i >= 0; i--) begin
          if ((e.s0.valid && model_q[i].id == e.s0.entry.id) ||
              (e.s1.valid && model_q[i].id == e.s1.entry.id))
            model_q.delete(i);
        end
        if (e.free >= 2) begin  // pushes accepted only without stall.
          if (push0)
            model_q.push_back(entry_in0);
          if (push1)
            model_q.push_back(entry_in1);
        end
      end
    end
  end

  initial begin
    void'($urandom(32'he702));
    reset = 1'b1;
    flush = 1'b0;
    push0 = 1'b0;
    push1 = 1'b0;
    entry_in0 = '0;
    entry_in1 = '0;
    dec_instruction = '0;
    dec_is_load = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    flush = 1'b1;  // pushes under flush vanish.
    step(1'b1, make_instr(6'h08, 1, 2, 3), 1'b1, make_instr(6'h08, 4, 5, 6));
    flush = 1'b0;
    step(1'b1, make_instr(6'h08, 1, 2, 3), 1'b1, make_instr(6'h08, 4, 5, 6));
    step(1'b1, make_instr(6'h08, 7, 8, 9), 1'b1, make_instr(6'h08, 10, 11, 12));
    wait_drain();
    // raw chain.
    step(1'b1, make_instr(6'h08, 1, 2, 3), 1'b1, make_instr(6'h08, 3, 4, 5));
    step(1'b1, make_instr(6'h18, 5, 6, 0), 1'b0, '0);
    wait_drain();
    dec_instruction = {`OP_LW, 5'd1, 5'd9, 16'd0};
    dec_is_load = 1'b1;
    step(1'b1, make_instr(6'h08, 9, 2, 3), 1'b1, make_instr(6'h08, 4, 5, 6));
    repeat (3) step(1'b0, '0, 1'b0, '0);
    dec_is_load = 1'b0;
    wait_drain();
    // steering pairs.
    step(1'b1, make_instr(`OP_LW, 1, 2, 0), 1'b1, make_instr(6'h08, 3, 4, 5));
    step(1'b1, make_instr(6'h08, 6, 7, 8), 1'b1, make_instr(6'h30, 9, 0, 0));
    step(1'b1, make_instr(`OP_LW, 1, 10, 0), 1'b1, make_instr(`OP_SW, 11, 12, 0));
    step(1'b1, make_instr(`OP_CMP, 13, 14, 15), 1'b1, make_instr(6'h30, 0, 0, 0));
    wait_drain();
    // hold every entry on r7 until the window stalls.
    dec_instruction = {`OP_LW, 5'd0, 5'd7, 16'd0};
    dec_is_load = 1'b1;
    repeat (6) step(1'b1, make_instr(6'h18, 7, 20, 0), 1'b1, make_instr(6'h18, 7, 21, 0));
    dec_is_load = 1'b0;
    wait_drain();
    for (int n = 0; n < 400; n++) begin
      flush = ($urandom % 16) == 0;
      dec_is_load = $urandom % 2;
      dec_instruction = {`OP_LW, 5'($urandom % 8), 5'($urandom % 8), 16'($urandom)};
      step($urandom % 2, rand_instr(), $urandom % 2, rand_instr());
    end
    flush = 1'b0;
    dec_is_load = 1'b0;
    wait_drain();
    @(posedge clk);
    #9;
    $display("checks %0d errors %0d timeouts %0d assertion failures %0d",
             checks, errors, timeouts, UUT.checks.failures);
    if (errors == 0 && timeouts == 0 && UUT.checks.failures == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== hdl/dual_select.sv ====
`timescale 1ns/1ps

`include "issue_settings.svh"

module dual_select (
  input  logic                        flush,
  input  logic [`ISSUE_DEPTH-1:0]     ready,
  input  issue_pkg::pipe_class_t      pipe_class [`ISSUE_DEPTH],
  input  issue_pkg::instr_entry_t     entries    [`ISSUE_DEPTH],
  output logic                        pop0,
  output logic                        pop1,
  output logic [`ISSUE_KEY_BITS-1:0]  pop_key0,
  output logic [`ISSUE_KEY_BITS-1:0]  pop_key1,
  output issue_pkg::issue_slot_t      slot0,
  output issue_pkg::issue_slot_t      slot1
);
  import issue_pkg::*;

  logic         pick0;
  logic         pick1;
  pipe_class_t  class0;
  pipe_class_t  class1;
  logic         swap;
  issue_slot_t  first_slot;
  issue_slot_t  second_slot;

  //////////////////////////////////////////////////////////////////////
  // picks
  //////////////////////////////////////////////////////////////////////

  // walk down so the oldest ready entry wins.
  always_comb begin
    pick0 = 1'b0;
    pop_key0 = '0;
    for (int i = `ISSUE_DEPTH-1; i >= 0; i--) begin
      if (ready[i]) begin
        pick0 = 1'b1;
        pop_key0 = `ISSUE_KEY_BITS'(i);
      end
    end
  end

  assign class0 = pipe_class[pop_key0];

  always_comb begin
    pick1 = 1'b0;
    pop_key1 = '0;
    for (int i = `ISSUE_DEPTH-1; i >= 0; i--) begin
      // no second branch or second memory op in one cycle.
      if (ready[i] && pop_key0 != i && !(pipe_class[i] == class0 && class0 != pipe_any)) begin
        pick1 = 1'b1;
        pop_key1 = `ISSUE_KEY_BITS'(i);
      end
    end
  end

  assign class1 = pipe_class[pop_key1];
  assign pop0   = pick0 && !flush;
  assign pop1   = pick1 && !flush;

  //////////////////////////////////////////////////////////////////////
  // slot steering
  //////////////////////////////////////////////////////////////////////

  assign swap = (class0 == pipe_memory) || (pick1 && class1 == pipe_branch);

  always_comb begin
    first_slot        = '0;
    second_slot       = '0;
    first_slot.valid  = pick0;
    second_slot.valid = pick1;
    if (pick0) first_slot.entry = entries[pop_key0];
    if (pick1) second_slot.entry = entries[pop_key1];
  end

  always_comb begin
    slot0 = '0;
    slot1 = '0;
    if (!flush) begin
      slot0 = swap ? second_slot : first_slot;
      slot1 = swap ? first_slot : second_slot;  // memory lane.
    end
  end

endmodule

// ==== hdl/issue_pkg.sv ====
`include "issue_settings.svh"

package issue_pkg;

  //////////////////////////////////////////////////////////////////////
  // window payload
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                   branch_taken;
    logic [`ADDR_WIDTH-1:0] branch_target;
    logic [`ID_WIDTH-1:0]   id;
    logic [`INST_WIDTH-1:0] instruction;
    logic [`ADDR_WIDTH-1:0] pc;
  } instr_entry_t;

  //////////////////////////////////////////////////////////////////////
  // register use of one instruction
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [`REG_BITS-1:0] src0;
    logic [`REG_BITS-1:0] src1;
    logic [`REG_BITS-1:0] dest;
    logic                 uses_src0;
    logic                 uses_src1;
    logic                 writes_dest;
  } reg_use_t;

  // lane an instruction needs.
  typedef enum logic [1:0] {
    pipe_any    = 2'd0,
    pipe_branch = 2'd1,  // slot 0 lane.
    pipe_memory = 2'd2   // slot 1 lane.
  } pipe_class_t;

  //////////////////////////////////////////////////////////////////////
  // issue slot
  //////////////////////////////////////////////////////////////////////

  // all zero when nothing issues.
  typedef struct packed {
    logic         valid;
    instr_entry_t entry;
  } issue_slot_t;

endpackage

// ==== hdl/issue_settings.svh ====
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// window geometry.
`define ISSUE_DEPTH     8
`define ISSUE_KEY_BITS  3

`define INST_WIDTH      32
`define ADDR_WIDTH      32
`define ID_WIDTH        6
`define REG_BITS        5

// instruction fields.
`define OPCODE_MSB      31
`define OPCODE_LSB      26
`define RS_MSB          25
`define RS_LSB          21
`define RT_MSB          20
`define RT_LSB          16
`define RD_MSB          15
`define RD_LSB          11

`define OP_NOP          6'b000000
`define OP_JR           6'b000001
`define OP_CMP          6'b000110  // register compares.
`define OP_TEST         6'b000111
`define OP_CMPI         6'b010110  // immediate compares.
`define OP_TESTI        6'b010111
`define OP_LW           6'b100000
`define OP_SW           6'b100001

// top two opcode bits.
`define OP_GRP_ALU_REG  2'b00
`define OP_GRP_ALU_IMM  2'b01
`define OP_GRP_MEM      2'b10
`define OP_GRP_BRANCH   2'b11

`endif

// ==== hdl/issue_stage.sv ====
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_stage (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      push0,
  input  logic                      push1,
  input  issue_pkg::instr_entry_t   entry_in0,
  input  issue_pkg::instr_entry_t   entry_in1,
  input  logic [`INST_WIDTH-1:0]    dec_instruction,
  input  logic                      dec_is_load,
  output logic                      stall,
  output logic [`ISSUE_KEY_BITS:0]  free,
  output issue_pkg::issue_slot_t    slot0,
  output issue_pkg::issue_slot_t    slot1
);

  logic [`ISSUE_DEPTH-1:0]      occupied;
  issue_pkg::instr_entry_t      entries    [`ISSUE_DEPTH];
  logic [`ISSUE_DEPTH-1:0]      ready;
  issue_pkg::pipe_class_t       pipe_class [`ISSUE_DEPTH];
  logic                         pop0;
  logic                         pop1;
  logic [`ISSUE_KEY_BITS-1:0]   pop_key0;
  logic [`ISSUE_KEY_BITS-1:0]   pop_key1;

  issue_window window (
    .clk(clk), .reset(reset), .flush(flush),
    .push0(push0), .push1(push1), .push_entry0(entry_in0), .push_entry1(entry_in1),
    .pop0(pop0), .pop1(pop1), .pop_key0(pop_key0), .pop_key1(pop_key1),
    .occupied(occupied), .entries(entries), .free(free), .stall(stall)
  );

  operand_hazard hazard (
    .occupied(occupied), .entries(entries),
    .dec_instruction(dec_instruction), .dec_is_load(dec_is_load), .ready(ready)
  );

  pipe_classify classify (.entries(entries), .pipe_class(pipe_class));

  dual_select select (
    .flush(flush), .ready(ready), .pipe_class(pipe_class), .entries(entries),
    .pop0(pop0), .pop1(pop1), .pop_key0(pop_key0), .pop_key1(pop_key1),
    .slot0(slot0), .slot1(slot1)
  );

endmodule

// ==== hdl/issue_window.sv ====
`timescale 1ns/1ps

`include "issue_settings.svh"

module issue_window (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        flush,
  input  logic                        push0,
  input  logic                        push1,
  input  issue_pkg::instr_entry_t     push_entry0,
  input  issue_pkg::instr_entry_t     push_entry1,
  input  logic                        pop0,
  input  logic                        pop1,
  input  logic [`ISSUE_KEY_BITS-1:0]  pop_key0,
  input  logic [`ISSUE_KEY_BITS-1:0]  pop_key1,
  output logic [`ISSUE_DEPTH-1:0]     occupied,
  output issue_pkg::instr_entry_t     entries [`ISSUE_DEPTH],
  output logic [`ISSUE_KEY_BITS:0]    free,
  output logic                        stall
);
  import issue_pkg::*;

  localparam logic [`ISSUE_KEY_BITS:0] full_count = `ISSUE_DEPTH;

  instr_entry_t                 next_entries [`ISSUE_DEPTH];
  logic [`ISSUE_DEPTH-1:0]      next_occupied;
  logic [`ISSUE_KEY_BITS:0]     fill;
  logic                         accept;

  // two free slots needed so a double push always fits.
  assign stall  = free < 2;
  assign accept = !stall && !flush;

  always_comb begin
    next_entries = entries;
    fill = '0;
    // survivors slide down, age order kept.
    for (int i = 0; i < `ISSUE_DEPTH; i++) begin
      if (occupied[i] && !(pop0 && pop_key0 == i) && !(pop1 && pop_key1 == i)) begin
        next_entries[fill[`ISSUE_KEY_BITS-1:0]] = entries[i];
        fill = fill + 1'b1;
      end
    end
    if (accept && push0) begin
      next_entries[fill[`ISSUE_KEY_BITS-1:0]] = push_entry0;
      fill = fill + 1'b1;
    end
    if (accept && push1) begin  // younger than push0.
      next_entries[fill[`ISSUE_KEY_BITS-1:0]] = push_entry1;
      fill = fill + 1'b1;
    end
    for (int i = 0; i < `ISSUE_DEPTH; i++) begin
      next_occupied[i] = i < fill;
    end
  end

  always_ff @(posedge clk) begin
    entries <= next_entries;
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      occupied <= '0;
      free     <= full_count;
    end else begin
      occupied <= next_occupied;
      free     <= full_count - fill;
    end
  end

endmodule

// ==== hdl/operand_hazard.sv ====
`timescale 1ns/1ps

`include "issue_settings.svh"

module operand_hazard (
  input  logic [`ISSUE_DEPTH-1:0]   occupied,
  input  issue_pkg::instr_entry_t   entries [`ISSUE_DEPTH],
  input  logic [`INST_WIDTH-1:0]    dec_instruction,
  input  logic                      dec_is_load,
  output logic [`ISSUE_DEPTH-1:0]   ready
);
  import issue_pkg::*;

  reg_use_t                  reg_use [`ISSUE_DEPTH];
  logic [`ISSUE_DEPTH-1:0]   raw_hit;
  logic [`ISSUE_DEPTH-1:0]   load_hit;
  logic [`REG_BITS-1:0]      dec_rt;

  function automatic reg_use_t decode_use(input logic [`INST_WIDTH-1:0] inst);
    reg_use_t                          u;
    logic [`OPCODE_MSB-`OPCODE_LSB:0]  op;
    logic [`REG_BITS-1:0]              rs;
    logic [`REG_BITS-1:0]              rt;
    logic [`REG_BITS-1:0]              rd;
    op = inst[`OPCODE_MSB:`OPCODE_LSB];
    rs = inst[`RS_MSB:`RS_LSB];
    rt = inst[`RT_MSB:`RT_LSB];
    rd = inst[`RD_MSB:`RD_LSB];
    u  = '0;
    if (op == `OP_JR) begin
      u.src0 = rs;
      u.uses_src0 = 1'b1;
    end else if (op != `OP_NOP) begin
      case (inst[`OPCODE_MSB -: 2])
        `OP_GRP_ALU_REG: u = '{src0: rs, src1: rt, dest: rd, uses_src0: 1'b1,
                               uses_src1: 1'b1, writes_dest: 1'b1};
        `OP_GRP_ALU_IMM: u = '{src0: rs, src1: '0, dest: rt, uses_src0: 1'b1,
                               uses_src1: 1'b0, writes_dest: 1'b1};
        `OP_GRP_MEM: begin
          if (op == `OP_LW)
            u = '{src0: rs, src1: '0, dest: rt, uses_src0: 1'b1,
                  uses_src1: 1'b0, writes_dest: 1'b1};
          else if (op == `OP_SW)
            u = '{src0: rs, src1: rt, dest: '0, uses_src0: 1'b1,
                  uses_src1: 1'b1, writes_dest: 1'b0};
        end
        default: u = '0;  // branches.
      endcase
    end
    return u;
  endfunction

  function automatic logic reads_reg(input reg_use_t u, input logic [`REG_BITS-1:0] r);
    return (u.uses_src0 && u.src0 == r) || (u.uses_src1 && u.src1 == r);
  endfunction

  assign dec_rt = dec_instruction[`RT_MSB:`RT_LSB];

  always_comb begin
    for (int i = 0; i < `ISSUE_DEPTH; i++) begin
      reg_use[i] = decode_use(entries[i].instruction);
    end
  end

  always_comb begin
    for (int i = 0; i < `ISSUE_DEPTH; i++) begin
      raw_hit[i] = 1'b0;
      for (int j = 0; j < i; j++) begin  // older entries only.
        if (occupied[j] && reg_use[j].writes_dest && reads_reg(reg_use[i], reg_use[j].dest))
          raw_hit[i] = 1'b1;
      end
      load_hit[i] = dec_is_load && reads_reg(reg_use[i], dec_rt);
    end
  end

  assign ready = occupied & ~raw_hit & ~load_hit;

endmodule

// ==== hdl/pipe_classify.sv ====
`timescale 1ns/1ps

`include "issue_settings.svh"

module pipe_classify (
  input  issue_pkg::instr_entry_t  entries    [`ISSUE_DEPTH],
  output issue_pkg::pipe_class_t   pipe_class [`ISSUE_DEPTH]
);
  import issue_pkg::*;

  function automatic pipe_class_t classify(input logic [`OPCODE_MSB-`OPCODE_LSB:0] op);
    pipe_class_t c;
    if (op[$high(op) -: 2] == `OP_GRP_MEM)
      c = pipe_memory;
    else if (op[$high(op) -: 2] == `OP_GRP_BRANCH)
      c = pipe_branch;
    // compares and jr feed the branch unit too.
    else if (op == `OP_JR || op == `OP_CMP || op == `OP_TEST ||
             op == `OP_CMPI || op == `OP_TESTI)
      c = pipe_branch;
    else
      c = pipe_any;
    return c;
  endfunction

  always_comb begin
    for (int i = 0; i < `ISSUE_DEPTH; i++) begin
      pipe_class[i] = classify(entries[i].instruction[`OPCODE_MSB:`OPCODE_LSB]);
    end
  end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/issue_pkg.sv
hdl/issue_window.sv
hdl/operand_hazard.sv
hdl/pipe_classify.sv
hdl/dual_select.sv
hdl/issue_stage.sv
bench/issue_stage_properties.sv
bench/issue_stage_tb.sv
